/* files.f */
rtl/stream_pkg.sv
rtl/tag_pkg.sv
rtl/lane_dispatch.sv
rtl/header_adder.sv
rtl/lane_tagger.sv
rtl/lane_merge.sv
rtl/tag_insert_top.sv
tests/tb_tag_insert.sv

/* Bender.yml */
package:
  name: tag_insert

sources:
  - rtl/stream_pkg.sv
  - rtl/tag_pkg.sv
  - rtl/lane_dispatch.sv
  - rtl/header_adder.sv
  - rtl/lane_tagger.sv
  - rtl/lane_merge.sv
  - rtl/tag_insert_top.sv
  - target: test
    files:
      - tests/tb_tag_insert.sv

/* tests/tb_tag_insert.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tag_insert
  import stream_pkg::*;
();

  localparam int num_entries = 12;

  // Words per packet, bytes in the last word, tdest, tuser, back-pressure on
  int tbl_words [num_entries] = '{1, 1, 1, 1, 3, 2, 2, 1, 4, 2, 3, 5};
  int tbl_last  [num_entries] = '{1, 4, 5, 8, 8, 3, 6, 2, 7, 4, 1, 5};
  int tbl_dest  [num_entries] = '{0, 1, 2, 3, 0, 4, 5, 2, 3, 6, 9, 15};
  int tbl_user  [num_entries] = '{3, 5, 1, 9, 2, 7, 4, 6, 8, 15, 0, 12};
  int tbl_bp    [num_entries] = '{0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1};

  logic  clk = 1'b0;
  logic  rst;
  data_t s_tdata;
  keep_t s_tkeep;
  dest_t s_tdest;
  user_t s_tuser;
  logic  s_tlast;
  logic  s_tvalid;
  logic  s_tready;
  data_t m_tdata;
  keep_t m_tkeep;
  dest_t m_tdest;
  user_t m_tuser;
  logic  m_tlast;
  logic  m_tvalid;
  logic  m_tready;

  data_t       exp_data [$];
  keep_t       exp_keep [$];
  dest_t       exp_dest [$];
  user_t       exp_user [$];
  logic        exp_last [$];
  logic [15:0] seq_cnt [4];
  logic [31:0] pay_rng;
  logic [31:0] rdy_rng;
  logic        bp_on;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          pkt_rx = 0;
  int          cycle_cnt = 0;
  int          limit;

  tag_insert_top i_dut (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tdest  (s_tdest),
    .s_tuser  (s_tuser),
    .s_tlast  (s_tlast),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tdest  (m_tdest),
    .m_tuser  (m_tuser),
    .m_tlast  (m_tlast),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  // Queues the expected output words, then drives the packet word by word
  task automatic send_packet(input int idx);
    int          words;
    int          nbytes;
    logic [1:0]  lane;
    logic [31:0] tag;
    logic [7:0]  obytes [$];
    data_t       d;
    keep_t       k;
    words  = tbl_words[idx];
    nbytes = 8 * (words - 1) + tbl_last[idx];
    lane   = tbl_dest[idx][1:0];
    tag    = {6'd0, lane, tbl_user[idx][3:0], tbl_dest[idx][3:0], seq_cnt[lane]};
    seq_cnt[lane]++;
    for (int b = 0; b < 4; b++) begin
      obytes.push_back(tag[8*b +: 8]);
    end
    for (int b = 0; b < nbytes; b++) begin
      pay_rng = xorshift(pay_rng);
      obytes.push_back(pay_rng[7:0]);
    end
    for (int w = 0; w < (nbytes + 11) / 8; w++) begin
      d = '0;
      k = '0;
      for (int b = 0; b < 8; b++) begin
        if (8 * w + b < nbytes + 4) begin
          d[8*b +: 8] = obytes[8*w+b];
          k[b] = 1'b1;
        end
      end
      exp_data.push_back(d);
      exp_keep.push_back(k);
      exp_dest.push_back(dest_t'(tbl_dest[idx]));
      exp_user.push_back(user_t'(tbl_user[idx]));
      exp_last.push_back(8 * w + 8 >= nbytes + 4);
    end
    bp_on = (tbl_bp[idx] != 0);
    for (int w = 0; w < words; w++) begin
      d = '0;
      k = '0;
      for (int b = 0; b < 8; b++) begin
        if (8 * w + b < nbytes) begin
          d[8*b +: 8] = obytes[4+8*w+b];
          k[b] = 1'b1;
        end
      end
      s_tdata  = d;
      s_tkeep  = k;
      s_tdest  = dest_t'(tbl_dest[idx]);
      s_tuser  = user_t'(tbl_user[idx]);
      s_tlast  = (w == words - 1);
      s_tvalid = 1'b1;
      @(negedge clk);
      while (!s_tready) begin
        @(negedge clk);
      end
      @(posedge clk);
      #2;
    end
  endtask

  // The ready level is chosen at the edge and applied shortly after it
  always @(posedge clk) begin : ready_gen
    logic nxt;
    rdy_rng = xorshift(rdy_rng);
    nxt = !bp_on || (rdy_rng[1:0] != 2'b00);
    #2;
    m_tready = nxt;
  end

  always @(negedge clk) begin : monitor
    keep_t k_exp;
    data_t mask;
    if (!rst && m_tvalid && m_tready) begin
      if (exp_data.size() == 0) begin
        err_cnt++;
        $display("Output word at %0t ns arrived when no packet was expected", $time);
      end else begin
        k_exp = exp_keep.pop_front();
        for (int b = 0; b < keep_w; b++) begin
          mask[8*b +: 8] = {8{k_exp[b]}};
        end
        check_value("m_tdata", m_tdata & mask, exp_data.pop_front());
        check_value("m_tkeep", m_tkeep, k_exp);
        check_value("m_tdest", m_tdest, exp_dest.pop_front());
        check_value("m_tuser", m_tuser, exp_user.pop_front());
        check_value("m_tlast", m_tlast, exp_last.pop_front());
        if (m_tlast) begin
          pkt_rx++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= limit) begin
      $display("Timeout after %0d cycles with %0d output words still missing",
               cycle_cnt, exp_data.size());
      err_cnt++;
      end_run();
    end
  end

  initial begin
    limit = 200;
    for (int i = 0; i < num_entries; i++) begin
      limit += 40 * tbl_words[i];
    end
    for (int i = 0; i < 4; i++) begin
      seq_cnt[i] = '0;
    end
    rst      = 1'b1;
    s_tdata  = '0;
    s_tkeep  = '0;
    s_tdest  = '0;
    s_tuser  = '0;
    s_tlast  = 1'b0;
    s_tvalid = 1'b0;
    m_tready = 1'b1;
    bp_on    = 1'b0;
    pay_rng  = 32'd6655;
    rdy_rng  = xorshift(32'd6655);
    repeat (4) @(posedge clk);
    #2;
    rst = 1'b0;
    // With nothing offered the output must stay idle
    @(negedge clk);
    check_value("m_tvalid", m_tvalid, 1'b0);
    @(posedge clk);
    #2;
    for (int i = 0; i < num_entries; i++) begin
      send_packet(i);
    end
    s_tvalid = 1'b0;
    s_tlast  = 1'b0;
    while (exp_data.size() != 0) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    check_value("packet count", pkt_rx, num_entries);
    end_run();
  end

endmodule

`default_nettype wire

/* rtl/tag_insert_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_insert_top
  import stream_pkg::*, tag_pkg::*;
(
  input  wire         clk,
  input  wire         rst,

  input  wire data_t  s_tdata,
  input  wire keep_t  s_tkeep,
  input  wire dest_t  s_tdest,
  input  wire user_t  s_tuser,
  input  wire         s_tlast,
  input  wire         s_tvalid,
  output logic        s_tready,

  output data_t       m_tdata,
  output keep_t       m_tkeep,
  output dest_t       m_tdest,
  output user_t       m_tuser,
  output logic        m_tlast,
  output logic        m_tvalid,
  input  wire         m_tready
);

  // Dispatcher to lanes
  data_t                in_tdata [num_lanes];
  keep_t                in_tkeep [num_lanes];
  dest_t                in_tdest [num_lanes];
  user_t                in_tuser [num_lanes];
  logic [num_lanes-1:0] in_tlast;
  logic [num_lanes-1:0] in_tvalid;
  logic [num_lanes-1:0] in_tready;

  // Lanes to merger
  data_t                out_tdata [num_lanes];
  keep_t                out_tkeep [num_lanes];
  dest_t                out_tdest [num_lanes];
  user_t                out_tuser [num_lanes];
  logic [num_lanes-1:0] out_tlast;
  logic [num_lanes-1:0] out_tvalid;
  logic [num_lanes-1:0] out_tready;

  lane_dispatch i_dispatch (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tdest  (s_tdest),
    .s_tuser  (s_tuser),
    .s_tlast  (s_tlast),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (in_tdata),
    .m_tkeep  (in_tkeep),
    .m_tdest  (in_tdest),
    .m_tuser  (in_tuser),
    .m_tlast  (in_tlast),
    .m_tvalid (in_tvalid),
    .m_tready (in_tready)
  );

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    lane_tagger #(
      .lane_id (lane_t'(i))
    ) i_tagger (
      .clk      (clk),
      .rst      (rst),
      .s_tdata  (in_tdata[i]),
      .s_tkeep  (in_tkeep[i]),
      .s_tdest  (in_tdest[i]),
      .s_tuser  (in_tuser[i]),
      .s_tlast  (in_tlast[i]),
      .s_tvalid (in_tvalid[i]),
      .s_tready (in_tready[i]),
      .m_tdata  (out_tdata[i]),
      .m_tkeep  (out_tkeep[i]),
      .m_tdest  (out_tdest[i]),
      .m_tuser  (out_tuser[i]),
      .m_tlast  (out_tlast[i]),
      .m_tvalid (out_tvalid[i]),
      .m_tready (out_tready[i])
    );
  end

  lane_merge i_merge (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (out_tdata),
    .s_tkeep  (out_tkeep),
    .s_tdest  (out_tdest),
    .s_tuser  (out_tuser),
    .s_tlast  (out_tlast),
    .s_tvalid (out_tvalid),
    .s_tready (out_tready),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tdest  (m_tdest),
    .m_tuser  (m_tuser),
    .m_tlast  (m_tlast),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
  );

endmodule

`default_nettype wire

/* rtl/lane_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_merge
  import stream_pkg::*, tag_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,

  input  wire data_t            s_tdata [num_lanes],
  input  wire keep_t            s_tkeep [num_lanes],
  input  wire dest_t            s_tdest [num_lanes],
  input  wire user_t            s_tuser [num_lanes],
  input  wire  [num_lanes-1:0]  s_tlast,
  input  wire  [num_lanes-1:0]  s_tvalid,
  output logic [num_lanes-1:0]  s_tready,

  output data_t                 m_tdata,
  output keep_t                 m_tkeep,
  output dest_t                 m_tdest,
  output user_t                 m_tuser,
  output logic                  m_tlast,
  output logic                  m_tvalid,
  input  wire                   m_tready
);

  logic  locked_q;
  lane_t lock_lane_q;
  lane_t ptr_q;
  lane_t grant;
  lane_t idx;
  logic  found;
  logic  m_hs;

  // Search from the pointer upward and wrap, unless a packet holds the output
  always_comb begin
    grant = ptr_q;
    found = 1'b0;
    idx   = ptr_q;
    for (int k = 0; k < num_lanes; k++) begin
      idx = lane_t'(ptr_q + k);
      if (!found && s_tvalid[idx]) begin
        grant = idx;
        found = 1'b1;
      end
    end
    if (locked_q) begin
      grant = lock_lane_q;
    end
  end

  assign m_tdata  = s_tdata[grant];
  assign m_tkeep  = s_tkeep[grant];
  assign m_tdest  = s_tdest[grant];
  assign m_tuser  = s_tuser[grant];
  assign m_tlast  = s_tlast[grant];
  assign m_tvalid = s_tvalid[grant];
  assign m_hs     = m_tvalid && m_tready;

  always_comb begin
    s_tready        = '0;
    s_tready[grant] = m_tready;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      locked_q    <= 1'b0;
      lock_lane_q <= '0;
      ptr_q       <= '0;
    end else if (m_hs) begin
      if (m_tlast) begin
        locked_q <= 1'b0;
        ptr_q    <= grant + lane_t'(1);
      end else begin
        locked_q    <= 1'b1;
        lock_lane_q <= grant;
      end
    end
  end

  // While a packet holds the output, every offered word belongs to the locked lane
  a_lock_held: assert property (@(posedge clk) disable iff (rst)
    locked_q && m_tvalid |-> lane_t'(m_tdest) == lock_lane_q);

endmodule

`default_nettype wire

/* rtl/lane_tagger.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_tagger
  import stream_pkg::*, tag_pkg::*;
#(
  parameter lane_t lane_id = '0
) (
  input  wire         clk,
  input  wire         rst,

  input  wire data_t  s_tdata,
  input  wire keep_t  s_tkeep,
  input  wire dest_t  s_tdest,
  input  wire user_t  s_tuser,
  input  wire         s_tlast,
  input  wire         s_tvalid,
  output logic        s_tready,

  output data_t       m_tdata,
  output keep_t       m_tkeep,
  output dest_t       m_tdest,
  output user_t       m_tuser,
  output logic        m_tlast,
  output logic        m_tvalid,
  input  wire         m_tready
);

  seq_t seq_q;
  hdr_t tag;

  // The adder samples the tag only with the first word, when s_tdest and
  // s_tuser belong to the packet being tagged
  always_comb begin
    tag = '0;
    tag[seq_lsb +: seq_w]   = seq_q;
    tag[dest_lsb +: dest_w] = s_tdest;
    tag[user_lsb +: user_w] = s_tuser;
    tag[lane_lsb +: lane_w] = lane_id;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      seq_q <= '0;
    end else if (m_tvalid && m_tready && m_tlast) begin
      seq_q <= seq_q + seq_t'(1);
    end
  end

  header_adder i_adder (
    .clk      (clk),
    .rst      (rst),
    .s_tdata  (s_tdata),
    .s_tkeep  (s_tkeep),
    .s_tdest  (s_tdest),
    .s_tuser  (s_tuser),
    .s_tlast  (s_tlast),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .hdr      (tag),
    .m_tdata  (m_tdata),
    .m_tkeep  (m_tkeep),
    .m_tdest  (m_tdest),
    .m_tuser  (m_tuser),
    .m_tlast  (m_tlast),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
  );

endmodule

`default_nettype wire

/* rtl/header_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module header_adder
  import stream_pkg::*, tag_pkg::*;
(
  input  wire         clk,
  input  wire         rst,

  input  wire data_t  s_tdata,
  input  wire keep_t  s_tkeep,
  input  wire dest_t  s_tdest,
  input  wire user_t  s_tuser,
  input  wire         s_tlast,
  input  wire         s_tvalid,
  output logic        s_tready,

  input  wire hdr_t   hdr,

  output data_t       m_tdata,
  output keep_t       m_tkeep,
  output dest_t       m_tdest,
  output user_t       m_tuser,
  output logic        m_tlast,
  output logic        m_tvalid,
  input  wire         m_tready
);

  // HDR sends the header with the first word, MID the words after it,
  // LST the bytes that spill out of the last input word
  typedef enum logic [1:0] {
    HDR,
    MID,
    LST
  } state_t;

  state_t                state_q;
  hdr_t                  rest_tdata_q;
  logic [hdr_keep_w-1:0] rest_tkeep_q;
  dest_t                 dest_q;
  user_t                 user_q;
  logic                  strb_left;
  logic                  s_hs;

  // Upper bytes of the word still in use, so they need a word of their own
  assign strb_left = |s_tkeep[keep_w-1 -: hdr_keep_w];
  assign s_hs      = s_tvalid && s_tready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= HDR;
    end else begin
      case (state_q)
        HDR, MID: begin
          if (s_hs) begin
            if (!s_tlast) begin
              state_q <= MID;
            end else if (strb_left) begin
              state_q <= LST;
            end else begin
              state_q <= HDR;
            end
          end
        end
        LST: begin
          if (m_tready) begin
            state_q <= HDR;
          end
        end
        default: state_q <= HDR;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (s_hs) begin
      rest_tdata_q <= s_tdata[data_w-1 -: hdr_w];
      rest_tkeep_q <= s_tkeep[keep_w-1 -: hdr_keep_w];
      if (state_q == HDR) begin
        dest_q <= s_tdest;
        user_q <= s_tuser;
      end
    end
  end

  always_comb begin
    case (state_q)
      HDR: begin
        m_tdata = {s_tdata[data_w-hdr_w-1:0], hdr};
        m_tkeep = {s_tkeep[keep_w-hdr_keep_w-1:0], {hdr_keep_w{1'b1}}};
      end
      MID: begin
        m_tdata = {s_tdata[data_w-hdr_w-1:0], rest_tdata_q};
        m_tkeep = {s_tkeep[keep_w-hdr_keep_w-1:0], rest_tkeep_q};
      end
      default: begin
        m_tdata = data_t'(rest_tdata_q);
        m_tkeep = keep_t'(rest_tkeep_q);
      end
    endcase
  end

  assign m_tdest  = (state_q == HDR) ? s_tdest : dest_q;
  assign m_tuser  = (state_q == HDR) ? s_tuser : user_q;
  assign m_tvalid = (state_q == LST) || s_tvalid;
  assign m_tlast  = (state_q == LST) || (s_tlast && !strb_left);
  // The input waits while the spilled bytes go out
  assign s_tready = (state_q != LST) && m_tready;

  // A stalled output word stays offered and unchanged until it is taken
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    m_tvalid && !m_tready |=>
      m_tvalid && $stable(m_tdata) && $stable(m_tkeep) && $stable(m_tlast));

endmodule

`default_nettype wire

/* rtl/lane_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_dispatch
  import stream_pkg::*, tag_pkg::*;
(
  input  wire                   clk,
  input  wire                   rst,

  input  wire data_t            s_tdata,
  input  wire keep_t            s_tkeep,
  input  wire dest_t            s_tdest,
  input  wire user_t            s_tuser,
  input  wire                   s_tlast,
  input  wire                   s_tvalid,
  output logic                  s_tready,

  output data_t                 m_tdata [num_lanes],
  output keep_t                 m_tkeep [num_lanes],
  output dest_t                 m_tdest [num_lanes],
  output user_t                 m_tuser [num_lanes],
  output logic [num_lanes-1:0]  m_tlast,
  output logic [num_lanes-1:0]  m_tvalid,
  input  wire  [num_lanes-1:0]  m_tready
);

  logic  busy_q;
  lane_t lane_q;
  lane_t sel;
  keep_t keep_inc;

  // The first word picks the lane, later words follow the stored choice
  assign sel = busy_q ? lane_q : lane_t'(s_tdest);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      lane_q <= '0;
    end else if (s_tvalid && s_tready) begin
      busy_q <= !s_tlast;
      lane_q <= sel;
    end
  end

  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      m_tdata[i]  = s_tdata;
      m_tkeep[i]  = s_tkeep;
      m_tdest[i]  = s_tdest;
      m_tuser[i]  = s_tuser;
      m_tlast[i]  = s_tlast;
      m_tvalid[i] = s_tvalid && (sel == lane_t'(i));
    end
  end

  assign s_tready = m_tready[sel];

  // Byte enables start at byte 0 with no holes, and only the last word may be short
  assign keep_inc = s_tkeep + keep_t'(1);

  a_keep_contig: assert property (@(posedge clk) disable iff (rst)
    s_tvalid && s_tready |->
      s_tkeep[0] && ((s_tkeep & keep_inc) == '0) && (s_tlast || (&s_tkeep)));

endmodule

`default_nettype wire

/* rtl/tag_pkg.sv */
`default_nettype none

// Lane structure and the layout of the tag header put in front of each packet
package tag_pkg;

  localparam int hdr_w      = 32;
  localparam int hdr_keep_w = hdr_w / 8;
  localparam int num_lanes  = 4;
  localparam int lane_w     = 2;
  localparam int seq_w      = 16;

  typedef logic [lane_w-1:0] lane_t;
  typedef logic [seq_w-1:0]  seq_t;
  typedef logic [hdr_w-1:0]  hdr_t;

  // Field positions inside the tag, all bits above the lane field are zero
  localparam int seq_lsb  = 0;
  localparam int dest_lsb = 16;
  localparam int user_lsb = 20;
  localparam int lane_lsb = 24;

endpackage

`default_nettype wire

/* rtl/stream_pkg.sv */
`default_nettype none

// Byte stream format shared by every block on the data path
package stream_pkg;

  localparam int data_w = 64;
  localparam int keep_w = data_w / 8;
  localparam int dest_w = 4;
  localparam int user_w = 4;

  // One bus word and its byte enables
  typedef logic [data_w-1:0] data_t;
  typedef logic [keep_w-1:0] keep_t;

  // Sideband fields carried with every word of a packet
  typedef logic [dest_w-1:0] dest_t;
  typedef logic [user_w-1:0] user_t;

endpackage

`default_nettype wire
